// File: flist.f
+incdir+verif
source/slurm16_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/interlock.sv
source/execute_stage.sv
source/memory_stage.sv
source/register_file.sv
source/slurm16_core.sv
verif/core_tb.sv

// File: verif/isa_model.svh
// ISA reference model: runs the program in model_mem one instruction at a time until halt
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Returns the number of instructions executed, or -1 if halt is never reached
function automatic int isa_model();
	word_t   r [16];
	word_t   pc;
	word_t   ins;
	word_t   a;
	word_t   b;
	word_t   y;
	word_t   imm;
	word_t   addr;
	logic [11:0] imm_hi;
	logic [16:0] wide;
	logic    z;
	logic    s;
	logic    c;
	logic    take;
	pc = '0;
	imm_hi = '0;
	z = 1'b0;
	s = 1'b0;
	c = 1'b0;
	for (int i = 0; i < 16; i++)
		r[i] = '0;
	for (int step = 0; step < 100000; step++) begin
		ins = model_mem[pc];
		imm = {imm_hi, ins[3:0]};
		pc = pc + 1'b1;
		case (ins[15:12])
			4'h0: begin
				if (ins == 16'h0100)
					return step + 1;
				if (ins[11:8] == 4'h2)
					r[ins[3:0]] = r[ins[3:0]] + 1'b1;    // inc, flags untouched
				else if (ins[11:8] == 4'h3)
					r[ins[3:0]] = r[ins[3:0]] - 1'b1;
			end
			4'h2, 4'h3: begin
				a = r[ins[7:4]];
				b = (ins[15:12] == 4'h2) ? r[ins[3:0]] : imm;
				wide = {1'b0, b};
				case (ins[11:8])
					4'h1: wide = {1'b0, a} + {1'b0, b};
					4'h2: wide = {1'b0, a} - {1'b0, b};    // Bit 16 is the borrow
					4'h3: wide = {1'b0, a & b};
					4'h4: wide = {1'b0, a | b};
					4'h5: wide = {1'b0, a ^ b};
					4'h6: wide = {1'b0, a[14:0], 1'b0};
					4'h7: wide = {2'b00, a[15:1]};
					default: wide = {1'b0, b};
				endcase
				y = wide[15:0];
				z = (y == 16'h0000);
				s = y[15];
				c = wide[16];
				r[ins[7:4]] = y;
			end
			4'h4: begin
				case (ins[10:8])
					3'd0: take = z;
					3'd1: take = !z;
					3'd2: take = s;
					3'd3: take = !s;
					3'd4: take = c;
					3'd5: take = !c;
					3'd6: take = 1'b1;
					default: take = 1'b0;
				endcase
				if (take)
					pc = imm;
			end
			4'h5, 4'h6: begin
				addr = (ins[15:12] == 4'h5) ? r[ins[3:0]] : imm;
				if (ins[8]) begin
					model_mem[addr] = r[ins[7:4]];
					model_written[addr] = 1'b1;
				end else begin
					r[ins[7:4]] = model_mem[addr];
				end
			end
			default: ;
		endcase
		imm_hi = (ins[15:12] == 4'h1) ? ins[11:0] : 12'h000;    // Prefix lasts one instruction
	end
	return -1;
endfunction

`endif

// File: verif/core_tb.sv
// Core testbench with a random-ready memory model, a program run to halt and a memory compare
`timescale 1ns/1ps
`default_nettype none

module core_tb import slurm16_pkg::*;;

	logic     CLK;
	logic     RSTb;
	logic     ready;
	word_t    rdata;
	mem_req_t mem_req;
	logic     halted;

	word_t    mem [65536];
	word_t    model_mem [65536];
	bit       model_written [65536];
	logic [31:0] rng;
	int       wait_cnt;
	int       errors;
	int       checks;
	int       steps;
	int       cycles;
	mem_req_t last_req;
	logic     last_pending;

	`include "isa_model.svh"

	// ALU tests, branches at 0x1E/0x23/0x29/0x36, dec loop at 0x3C, loads at 0x45
	// More ALU forms at 0x58 and halt at 0x6B
	localparam word_t program_words [0:107] = '{
		16'h1123, 16'h3014, 16'h3025, 16'h2112, 16'h1020, 16'h6110, 16'h2031, 16'h2232,
		16'h1020, 16'h6131, 16'h2332, 16'h1020, 16'h6132, 16'h3437, 16'h1020, 16'h6133,
		16'h3537, 16'h1020, 16'h6134, 16'h2611, 16'h1020, 16'h6115, 16'h2711, 16'h1020,
		16'h6116, 16'h3F49, 16'h1020, 16'h6147, 16'h2222, 16'h1002, 16'h4000, 16'h3067,
		16'h3061, 16'h2222, 16'h1002, 16'h410F, 16'h1020, 16'h6168, 16'h1800, 16'h3080,
		16'h1003, 16'h4232, 16'h3069, 16'h3069, 16'h3069, 16'h3069, 16'h3069, 16'h3069,
		16'h3069, 16'h3069, 16'h1FFF, 16'h309F, 16'h3191, 16'h1003, 16'h4408, 16'h306A,
		16'h1020, 16'h6169, 16'h30A5, 16'h30B0, 16'h020B, 16'h030A, 16'h24AA, 16'h1003,
		16'h413C, 16'h1020, 16'h61AA, 16'h1020, 16'h61BB, 16'h1020, 16'h60C0, 16'h020C,
		16'h020C, 16'h030C, 16'h21CC, 16'h1020, 16'h61CC, 16'h1020, 16'h30D1, 16'h50ED,
		16'h21EE, 16'h51ED, 16'h1100, 16'h60F7, 16'h1020, 16'h61FD, 16'h1123, 16'h6114,
		16'h24C1, 16'h1020, 16'h61CE, 16'h25E1, 16'h1020, 16'h61EF, 16'h32B7, 16'h1021,
		16'h61B0, 16'h10F0, 16'h35FF, 16'h1021, 16'h61F1, 16'h36E0, 16'h1021, 16'h61E2,
		16'h3780, 16'h1021, 16'h6183, 16'h0100
	};

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	slurm16_core slurm16_core_inst (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.rdata   (rdata),
		.ready   (ready),
		.mem_req (mem_req),
		.halted  (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = !CLK;
	end

	// Memory model whose ready comes 0 to 3 cycles after a request shows up
	always @(posedge CLK) begin
		if (RSTb && last_pending && (mem_req != last_req)) begin
			errors++;
			$display("Bus request changed while waiting for ready at %0t", $time);
		end
		last_pending <= RSTb && mem_req.valid && !ready;
		last_req     <= mem_req;
		if (ready) begin
			if (mem_req.valid && mem_req.wr)
				mem[mem_req.addr] <= mem_req.wdata;
			ready    <= 1'b0;
			rng       = xorshift(rng);
			wait_cnt <= rng % 4;
		end else if (RSTb && mem_req.valid) begin
			if (wait_cnt == 0) begin
				ready <= 1'b1;
				rdata <= mem[mem_req.addr];    // Request is held until ready
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	initial begin
		RSTb = 1'b0;
		ready = 1'b0;
		rdata = '0;
		rng = 32'd56686;
		wait_cnt = 0;
		errors = 0;
		checks = 0;
		last_pending = 1'b0;
		last_req = '0;
		for (int a = 0; a < 65536; a++) begin
			mem[a] = word_t'(a ^ (a << 5) ^ 16'h5A3C);
			model_written[a] = 1'b0;
		end
		for (int i = 0; i < $size(program_words); i++)
			mem[i] = program_words[i];
		for (int a = 0; a < 65536; a++)
			model_mem[a] = mem[a];
		steps = isa_model();
		if (steps < 0) begin
			errors++;
			$display("ISA model did not reach halt");
		end

		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		cycles = 0;
		while (!halted && cycles < 20000) begin
			@(posedge CLK);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("Timeout: halted did not rise within 20000 cycles");
		end else begin
			for (int i = 0; i < 16; i++) begin
				@(posedge CLK);
				if (mem_req.valid) begin
					errors++;
					$display("Bus request valid after halt at %0t", $time);
				end
			end
			for (int a = 0; a < 65536; a++)
				if (model_written[a])
					check($sformatf("mem[%h]", a), model_mem[a], mem[a]);
		end
		$display("Instructions: %0d, checks: %0d, errors: %0d", steps, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/slurm16_core.sv
// slurm16 core top: five-stage pipeline with register file on one valid/ready memory bus
`timescale 1ns/1ps
`default_nettype none

module slurm16_core import slurm16_pkg::*; (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire word_t rdata,
	input  wire logic  ready,
	output mem_req_t   mem_req,
	output logic       halted
);

	fetch_pkt_t  fetch_pkt;
	decode_pkt_t dec_pkt;
	exec_pkt_t   exe_pkt;
	wb_pkt_t     wb;
	mem_req_t    fetch_req;
	logic        grant;
	logic        mem_busy;
	logic        decode_stall;
	logic        fetch_hold;
	logic        branch_taken;
	word_t       branch_target;
	reg_idx_t    ra_addr;
	reg_idx_t    rb_addr;
	word_t       rd_a;
	word_t       rd_b;

	assign fetch_hold = mem_busy || decode_stall;    // Fetch waits for decode too

	fetch_stage u_fetch (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.ready         (ready),
		.rdata         (rdata),
		.grant         (grant),
		.hold          (fetch_hold),
		.flush         (branch_taken),
		.branch_target (branch_target),
		.halted        (halted),
		.fetch_req     (fetch_req),
		.fetch_pkt     (fetch_pkt)
	);

	decode_stage u_decode (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.fetch_pkt (fetch_pkt),
		.hold      (mem_busy),
		.flush     (branch_taken),
		.stall     (decode_stall),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.ra_addr   (ra_addr),
		.rb_addr   (rb_addr),
		.dec_pkt   (dec_pkt)
	);

	interlock u_interlock (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.fetch_pkt (fetch_pkt),
		.dec_pkt   (dec_pkt),
		.exe_pkt   (exe_pkt),
		.hold      (mem_busy),
		.stall     (decode_stall)
	);

	execute_stage u_execute (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.dec_pkt       (dec_pkt),
		.hold          (mem_busy),
		.exe_pkt       (exe_pkt),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	memory_stage u_memory (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.exe_pkt   (exe_pkt),
		.fetch_req (fetch_req),
		.ready     (ready),
		.rdata     (rdata),
		.mem_req   (mem_req),
		.grant     (grant),
		.mem_busy  (mem_busy),
		.wb        (wb),
		.halted    (halted)
	);

	register_file u_regs (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wb      (wb),
		.rd_a    (rd_a),
		.rd_b    (rd_b)
	);

endmodule

`default_nettype wire

// File: source/register_file.sv
// Register file: sixteen 16-bit registers with two combinational read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module register_file import slurm16_pkg::*; (
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire reg_idx_t ra_addr,
	input  wire reg_idx_t rb_addr,
	input  wire wb_pkt_t  wb,
	output word_t         rd_a,
	output word_t         rd_b
);

	word_t regs [16];

	// No bypass, the interlock keeps readers away from a pending write
	assign rd_a = regs[ra_addr];
	assign rd_b = regs[rb_addr];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wb.we) begin
			regs[wb.idx] <= wb.data;
		end
	end

endmodule

`default_nettype wire

// File: source/memory_stage.sv
// Memory stage: bus arbitration between data and fetch, load/store access and the writeback register
`timescale 1ns/1ps
`default_nettype none

module memory_stage import slurm16_pkg::*; (
	input  wire logic      CLK,
	input  wire logic      RSTb,
	input  wire exec_pkt_t exe_pkt,
	input  wire mem_req_t  fetch_req,
	input  wire logic      ready,
	input  wire word_t     rdata,
	output mem_req_t       mem_req,
	output logic           grant,
	output logic           mem_busy,
	output wb_pkt_t        wb,
	output logic           halted
);

	logic data_op;
	logic data_go;
	logic fetch_pending_r;    // Fetch already on the bus, must finish first
	logic retire;

	assign data_op  = exe_pkt.valid && (exe_pkt.load || exe_pkt.store);
	assign data_go  = data_op && !fetch_pending_r;
	assign grant    = !data_go;
	assign mem_busy = data_op && !(data_go && ready);
	assign retire   = exe_pkt.valid && !mem_busy;

	always_comb begin
		mem_req = fetch_req;
		if (data_go) begin
			mem_req.valid = 1'b1;
			mem_req.wr    = exe_pkt.store;
			mem_req.addr  = exe_pkt.addr;
			mem_req.wdata = exe_pkt.wdata;
		end
	end

	always_ff @(posedge CLK) begin
		wb.idx  <= exe_pkt.dest;
		wb.data <= exe_pkt.load ? rdata : exe_pkt.result;    // Load data taken on ready
		if (!RSTb) begin
			fetch_pending_r <= 1'b0;
			wb.we           <= 1'b0;
			halted          <= 1'b0;
		end else begin
			fetch_pending_r <= !data_go && fetch_req.valid && !ready;
			wb.we           <= retire && exe_pkt.dest_we;
			if (retire && exe_pkt.halt)
				halted <= 1'b1;    // Sticky
		end
	end

	// Whoever owns the bus keeps its request steady until ready
	a_req_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_req.valid && !ready |=> $stable(mem_req));

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// Execute stage: ALU, flags, branch resolution and the execute/memory register
`timescale 1ns/1ps
`default_nettype none

module execute_stage import slurm16_pkg::*; (
	input  wire logic        CLK,
	input  wire logic        RSTb,
	input  wire decode_pkt_t dec_pkt,
	input  wire logic        hold,
	output exec_pkt_t        exe_pkt,
	output logic             branch_taken,
	output word_t            branch_target
);

	word_t     a;
	word_t     b;
	word_t     alu_y;
	logic      alu_c;
	logic      z_r;
	logic      s_r;
	logic      c_r;
	logic      cond_true;
	exec_pkt_t nxt;

	assign a = dec_pkt.op_a;
	assign b = dec_pkt.op_b;

	always_comb begin
		alu_c = 1'b0;
		case (dec_pkt.alu_op)
			alu_mov: alu_y = b;
			alu_add: {alu_c, alu_y} = a + b;
			alu_sub: {alu_c, alu_y} = a - b;    // Borrow lands in alu_c
			alu_and: alu_y = a & b;
			alu_or:  alu_y = a | b;
			alu_xor: alu_y = a ^ b;
			alu_shl: alu_y = a << 1;
			alu_shr: alu_y = a >> 1;
			default: alu_y = b;    // Spare codes behave as mov
		endcase
	end

	always_comb begin
		case (branch_cond_t'(dec_pkt.instr[10:8]))
			cond_bz:  cond_true = z_r;
			cond_bnz: cond_true = !z_r;
			cond_bs:  cond_true = s_r;
			cond_bns: cond_true = !s_r;
			cond_bc:  cond_true = c_r;
			cond_bnc: cond_true = !c_r;
			cond_ba:  cond_true = 1'b1;
			default:  cond_true = 1'b0;
		endcase
	end

	// Taken only in the cycle the branch leaves execute
	assign branch_taken  = dec_pkt.valid && dec_pkt.is_branch && cond_true && !hold;
	assign branch_target = dec_pkt.imm;

	always_comb begin
		nxt.valid   = dec_pkt.valid;
		nxt.load    = dec_pkt.is_load;
		nxt.store   = dec_pkt.is_store;
		nxt.halt    = dec_pkt.is_halt;
		nxt.dest    = dec_pkt.dest;
		nxt.dest_we = dec_pkt.dest_we;
		if (dec_pkt.is_inc)
			nxt.result = b + 1'b1;
		else if (dec_pkt.is_dec)
			nxt.result = b - 1'b1;
		else
			nxt.result = alu_y;
		nxt.addr  = b;    // Register or immediate address
		nxt.wdata = a;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			exe_pkt.valid <= 1'b0;
			z_r           <= 1'b0;
			s_r           <= 1'b0;
			c_r           <= 1'b0;
		end else if (!hold) begin
			exe_pkt <= nxt;
			if (dec_pkt.valid && dec_pkt.is_alu) begin    // inc and dec leave flags alone
				z_r <= (alu_y == '0);
				s_r <= alu_y[word_w-1];
				c_r <= alu_c;
			end
		end
	end

	// A taken branch comes from a branch packet and leaves a bubble behind it
	a_branch_flush: assert property (@(posedge CLK) disable iff (!RSTb)
		branch_taken |-> dec_pkt.is_branch ##1 !dec_pkt.valid);

endmodule

`default_nettype wire

// File: source/interlock.sv
// Interlock that stalls decode on register hazards and on pending flag writers ahead of a branch
`timescale 1ns/1ps
`default_nettype none

module interlock import slurm16_pkg::*; (
	input  wire logic        CLK,
	input  wire logic        RSTb,
	input  wire fetch_pkt_t  fetch_pkt,
	input  wire decode_pkt_t dec_pkt,
	input  wire exec_pkt_t   exe_pkt,
	input  wire logic        hold,
	output logic             stall
);

	word_t    ins;
	logic     use_a;
	logic     use_b;
	logic     mem_flag_r;    // ALU op sitting in the memory stage
	logic     wb_we_r;       // Copy of the writeback write
	reg_idx_t wb_dest_r;
	logic     reg_hazard;
	logic     flag_hazard;

	function automatic logic clash(input logic we, input reg_idx_t dest);
		return we && ((use_a && (dest == ins[7:4])) || (use_b && (dest == ins[3:0])));
	endfunction

	assign ins   = fetch_pkt.instr;
	assign use_a = fetch_pkt.valid && reads_a(ins);
	assign use_b = fetch_pkt.valid && reads_b(ins);

	always_comb begin
		reg_hazard = clash(dec_pkt.valid && dec_pkt.dest_we, dec_pkt.dest) ||
			clash(exe_pkt.valid && exe_pkt.dest_we, exe_pkt.dest) ||
			clash(wb_we_r, wb_dest_r);
		flag_hazard = fetch_pkt.valid && is_cond_branch(ins) &&
			((dec_pkt.valid && dec_pkt.is_alu) || mem_flag_r);
		stall = reg_hazard || flag_hazard;
	end

	always_ff @(posedge CLK) begin
		wb_dest_r <= exe_pkt.dest;
		if (!RSTb) begin
			mem_flag_r <= 1'b0;
			wb_we_r    <= 1'b0;
		end else if (!hold) begin
			mem_flag_r <= dec_pkt.valid && dec_pkt.is_alu;
			wb_we_r    <= exe_pkt.valid && exe_pkt.dest_we;
		end else begin
			wb_we_r <= 1'b0;    // Memory stage sends no write while it waits
		end
	end

	// Three stall cycles with the bus moving drain every writer ahead of decode
	a_stall_drains: assert property (@(posedge CLK) disable iff (!RSTb)
		(stall && !hold) ##1 (stall && !hold) ##1 (stall && !hold) |=> !stall);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
// Decode stage: instruction decode, immediate prefix, register reads and the decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage import slurm16_pkg::*; (
	input  wire logic       CLK,
	input  wire logic       RSTb,
	input  wire fetch_pkt_t fetch_pkt,
	input  wire logic       hold,
	input  wire logic       flush,
	input  wire logic       stall,
	input  wire word_t      rd_a,
	input  wire word_t      rd_b,
	output reg_idx_t        ra_addr,
	output reg_idx_t        rb_addr,
	output decode_pkt_t     dec_pkt
);

	word_t       ins;
	logic [3:0]  op;
	logic        advance;
	imm_hi_t     imm_hi;    // Upper 12 bits from the last prefix
	decode_pkt_t nxt;

	assign ins     = fetch_pkt.instr;
	assign op      = ins[15:12];
	assign ra_addr = ins[7:4];
	assign rb_addr = ins[3:0];
	assign advance = fetch_pkt.valid && !stall;

	always_comb begin
		nxt           = '0;
		nxt.valid     = advance;    // Bubble while the interlock stalls
		nxt.instr     = ins;
		nxt.is_alu    = (op == op_alu_rr) || (op == op_alu_ri);
		nxt.is_inc    = (op == op_misc) && (ins[11:8] == misc_inc);
		nxt.is_dec    = (op == op_misc) && (ins[11:8] == misc_dec);
		nxt.is_branch = (op == op_branch);
		nxt.is_load   = ((op == op_mem_reg) || (op == op_mem_imm)) && !ins[8];
		nxt.is_store  = ((op == op_mem_reg) || (op == op_mem_imm)) && ins[8];
		nxt.is_halt   = (ins == halt_instruction);
		nxt.alu_op    = ins[11:8];

		// inc and dec name their register in the low nibble
		nxt.dest    = (nxt.is_inc || nxt.is_dec) ? ins[3:0] : ins[7:4];
		nxt.dest_we = nxt.is_alu || nxt.is_inc || nxt.is_dec || nxt.is_load;

		nxt.imm  = {imm_hi, ins[3:0]};
		nxt.op_a = rd_a;
		// Immediate operand, or the immediate address of op_mem_imm
		nxt.op_b = ((op == op_alu_ri) || (op == op_mem_imm)) ? nxt.imm : rd_b;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			dec_pkt.valid <= 1'b0;
			imm_hi        <= '0;
		end else if (flush) begin
			dec_pkt.valid <= 1'b0;
			imm_hi        <= '0;
		end else if (!hold) begin
			dec_pkt <= nxt;
			if (advance)
				imm_hi <= (op == op_imm) ? ins[11:0] : '0;    // Prefix lasts one instruction
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
// Fetch stage: program counter, instruction requests and the fetched-instruction register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import slurm16_pkg::*; (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire logic  ready,
	input  wire word_t rdata,
	input  wire logic  grant,
	input  wire logic  hold,
	input  wire logic  flush,
	input  wire word_t branch_target,
	input  wire logic  halted,
	output mem_req_t   fetch_req,
	output fetch_pkt_t fetch_pkt
);

	word_t pc;
	word_t req_addr_r;    // Address of the request on the bus
	logic  in_flight_r;   // Granted and still waiting for ready
	logic  discard_r;
	logic  stop_r;        // Halt fetched, stop requesting
	logic  slot_free;
	logic  accept;
	logic  keep_word;
	logic  waiting;

	// A new request only goes out if its word has somewhere to land
	assign slot_free = !fetch_pkt.valid || !hold;

	always_comb begin
		fetch_req.valid = in_flight_r || (!flush && !halted && !stop_r && slot_free);
		fetch_req.wr    = 1'b0;
		fetch_req.addr  = in_flight_r ? req_addr_r : pc;
		fetch_req.wdata = '0;
	end

	assign accept    = fetch_req.valid && grant && ready;
	assign waiting   = fetch_req.valid && grant && !ready;
	assign keep_word = accept && !discard_r && !flush;

	always_ff @(posedge CLK) begin
		req_addr_r <= fetch_req.addr;
		if (!RSTb) begin
			pc              <= '0;
			in_flight_r     <= 1'b0;
			discard_r       <= 1'b0;
			stop_r          <= 1'b0;
			fetch_pkt.valid <= 1'b0;
		end else begin
			in_flight_r <= waiting;
			// A flushed request still has to finish on the bus, its word is dropped
			discard_r   <= waiting && (discard_r || flush);

			if (flush)
				pc <= branch_target;
			else if (keep_word)
				pc <= pc + 1'b1;

			if (flush)
				stop_r <= 1'b0;
			else if (keep_word && (rdata == halt_instruction))
				stop_r <= 1'b1;

			if (keep_word)
				fetch_pkt <= '{valid: 1'b1, instr: rdata};
			else if (flush || !hold)
				fetch_pkt <= '{valid: 1'b0, instr: nop_instruction};    // Consumed or flushed
		end
	end

endmodule

`default_nettype wire

// File: source/slurm16_pkg.sv
// slurm16 shared widths, instruction encodings, decode helpers and pipeline packets
`default_nettype none

package slurm16_pkg;

	localparam int word_w = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [3:0]        reg_idx_t;
	typedef logic [11:0]       imm_hi_t;
	typedef logic [3:0]        alu_op_t;
	typedef logic [2:0]        branch_cond_t;

	// Opcode in the top nibble
	localparam logic [3:0] op_misc    = 4'h0;
	localparam logic [3:0] op_imm     = 4'h1;
	localparam logic [3:0] op_alu_rr  = 4'h2;
	localparam logic [3:0] op_alu_ri  = 4'h3;
	localparam logic [3:0] op_branch  = 4'h4;
	localparam logic [3:0] op_mem_reg = 4'h5;
	localparam logic [3:0] op_mem_imm = 4'h6;

	localparam logic [3:0] misc_inc = 4'h2;    // Bits 11:8 of op_misc
	localparam logic [3:0] misc_dec = 4'h3;

	localparam word_t nop_instruction  = 16'h0000;
	localparam word_t halt_instruction = 16'h0100;

	localparam alu_op_t alu_mov = 4'd0;
	localparam alu_op_t alu_add = 4'd1;
	localparam alu_op_t alu_sub = 4'd2;
	localparam alu_op_t alu_and = 4'd3;
	localparam alu_op_t alu_or  = 4'd4;
	localparam alu_op_t alu_xor = 4'd5;
	localparam alu_op_t alu_shl = 4'd6;
	localparam alu_op_t alu_shr = 4'd7;

	localparam branch_cond_t cond_bz  = 3'd0;
	localparam branch_cond_t cond_bnz = 3'd1;
	localparam branch_cond_t cond_bs  = 3'd2;
	localparam branch_cond_t cond_bns = 3'd3;
	localparam branch_cond_t cond_bc  = 3'd4;
	localparam branch_cond_t cond_bnc = 3'd5;
	localparam branch_cond_t cond_ba  = 3'd6;

	typedef struct packed {
		logic  valid;
		word_t instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic     valid;
		word_t    instr;
		logic     is_alu;
		logic     is_inc;
		logic     is_dec;
		logic     is_branch;
		logic     is_load;
		logic     is_store;
		logic     is_halt;
		alu_op_t  alu_op;
		reg_idx_t dest;
		logic     dest_we;
		word_t    op_a;
		word_t    op_b;
		word_t    imm;
	} decode_pkt_t;

	typedef struct packed {
		logic     valid;
		logic     load;
		logic     store;
		logic     halt;
		reg_idx_t dest;
		logic     dest_we;
		word_t    result;
		word_t    addr;
		word_t    wdata;
	} exec_pkt_t;

	typedef struct packed {
		logic     we;
		reg_idx_t idx;
		word_t    data;
	} wb_pkt_t;

	typedef struct packed {
		logic  valid;
		logic  wr;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	// Port A is bits 7:4, read by ALU ops and by stores for their data
	function automatic logic reads_a(input word_t ins);
		return (ins[15:12] == op_alu_rr) || (ins[15:12] == op_alu_ri) ||
			(((ins[15:12] == op_mem_reg) || (ins[15:12] == op_mem_imm)) && ins[8]);
	endfunction

	// Port B is bits 3:0
	function automatic logic reads_b(input word_t ins);
		return (ins[15:12] == op_alu_rr) || (ins[15:12] == op_mem_reg) ||
			((ins[15:12] == op_misc) && ((ins[11:8] == misc_inc) || (ins[11:8] == misc_dec)));
	endfunction

	function automatic logic is_cond_branch(input word_t ins);
		return (ins[15:12] == op_branch) && (ins[10:8] < cond_ba);
	endfunction

endpackage

`default_nettype wire
